// ==== rtl/zxuno_pkg.sv ====
package zxuno_pkg;

  // --------------------
  // bus widths
  // --------------------
  localparam int addr_w = 16;
  localparam int data_w = 8;

  // --------------------
  // i/o ports
  // --------------------
  // register address port, read back by the cpu
  localparam logic [addr_w-1:0] port_zxaddr = 16'hFC3B;
  // register data port, routed by the latched address
  localparam logic [addr_w-1:0] port_zxdata = 16'hFD3B;

  // --------------------
  // register numbers
  // --------------------
  localparam logic [data_w-1:0] reg_scandbl    = 8'h0B;
  localparam logic [data_w-1:0] reg_rasterline = 8'h0C;
  localparam logic [data_w-1:0] reg_rasterctl  = 8'h0D;
  localparam logic [data_w-1:0] reg_devoptions = 8'h0E;
  localparam logic [data_w-1:0] reg_coreid     = 8'hFF;

  // nobody drives the bus
  localparam logic [data_w-1:0] open_bus = 8'hFF;

  // raster line, 9 bits split across two registers
  localparam int raster_line_w = 9;
  localparam logic [raster_line_w-1:0] raster_line_rst = '1;

  // reset values of the bank
  localparam logic [data_w-1:0] scandbl_rst    = 8'h00;
  localparam logic [data_w-1:0] rasterline_rst = raster_line_rst[data_w-1:0];
  // only line_msb set, enables stay off
  localparam logic [data_w-1:0] rasterctl_rst  = {7'b0, raster_line_rst[raster_line_w-1]};
  localparam logic [data_w-1:0] devoptions_rst = 8'h00;

  // --------------------
  // core id
  // --------------------
  localparam int coreid_len   = 8;
  localparam int coreid_ptr_w = $clog2(coreid_len);
  // last entry is the terminating zero
  localparam logic [data_w-1:0] coreid_string [coreid_len] = '{
    "Z", "X", "I", "O", "-", "R", "1", 8'h00
  };

  // written byte, two ways of looking at it
  typedef union packed {
    // reg_scandbl view
    struct packed {
      logic [1:0] cpu_speed;
      logic       csync_option;
      logic [2:0] freq_option;
      logic       scanlines_enable;
      logic       vga_enable;
    } scandbl;
    // reg_rasterctl view
    struct packed {
      logic [4:0] unused;
      logic       vretraceint_disable;
      logic       rasterint_enable;
      logic       line_msb;
    } rasterctl;
  } zx_wdata_u;

endpackage

// ==== rtl/zxreg_if.sv ====
interface zxreg_if import zxuno_pkg::*; ();

  // latched register number
  logic [data_w-1:0] reg_addr;
  // byte from the cpu, valid with regwr
  logic [data_w-1:0] wdata;
  // one-cycle strobes, one per bus access
  logic              regwr;
  logic              regrd;
  logic              regaddr_changed;

  // decoder side
  modport source (
    output reg_addr, wdata, regwr, regrd, regaddr_changed
  );

  // register consumers, no back-pressure
  modport sink (
    input reg_addr, wdata, regwr, regrd, regaddr_changed
  );

endinterface

// ==== rtl/zxreg_decoder.sv ====
module zxreg_decoder import zxuno_pkg::*; (
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic [addr_w-1:0] addr,
  input  logic              iorq_n,
  input  logic              rd_n,
  input  logic              wr_n,
  input  logic [data_w-1:0] din,
  output logic [data_w-1:0] addr_dout,
  output logic              oe_addr,
  zxreg_if.source           zx
);

  logic              io_req;
  logic              cycle_seen;
  logic              start;
  logic              hit_addr;
  logic              hit_data;
  logic [data_w-1:0] regaddr_q;
  logic [data_w-1:0] wdata_q;
  logic              regwr_q;
  logic              regrd_q;
  logic              changed_q;

  // --------------------
  // cycle detect
  // --------------------
  // any i/o read or write on the bus
  assign io_req   = !iorq_n && (!rd_n || !wr_n);
  // first edge of the cycle only
  assign start    = io_req && !cycle_seen;
  assign hit_addr = (addr == port_zxaddr);
  assign hit_data = (addr == port_zxdata);

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      cycle_seen <= 1'b0;
      regaddr_q  <= '0;
      regwr_q    <= 1'b0;
      regrd_q    <= 1'b0;
      changed_q  <= 1'b0;
    end else begin
      // strobes drop after one cycle
      regwr_q   <= 1'b0;
      regrd_q   <= 1'b0;
      changed_q <= 1'b0;
      // rearm only once iorq_n is back high
      if (iorq_n)
        cycle_seen <= 1'b0;
      else if (io_req)
        cycle_seen <= 1'b1;
      // address port write
      if (start && hit_addr && !wr_n) begin
        regaddr_q <= din;
        changed_q <= 1'b1;
      end
      // data port, write wins if both low
      if (start && hit_data) begin
        regwr_q <= !wr_n;
        regrd_q <= wr_n && !rd_n;
      end
    end
  end

  // payload byte for regwr
  always_ff @(posedge sysclk) begin
    if (start && hit_data && !wr_n)
      wdata_q <= din;
  end

  // --------------------
  // outputs
  // --------------------
  assign zx.reg_addr        = regaddr_q;
  assign zx.wdata           = wdata_q;
  assign zx.regwr           = regwr_q;
  assign zx.regrd           = regrd_q;
  assign zx.regaddr_changed = changed_q;

  // address latch read-back
  assign oe_addr   = !iorq_n && !rd_n && hit_addr;
  assign addr_dout = regaddr_q;

endmodule

// ==== rtl/zxreg_bank.sv ====
module zxreg_bank import zxuno_pkg::*; (
  input  logic                     sysclk,
  input  logic                     rst_n,
  input  logic                     rd_n,
  input  logic                     iorq_n,
  input  logic [addr_w-1:0]        addr,
  zxreg_if.sink                    zx,
  output logic [data_w-1:0]        dout,
  output logic                     oe,
  output logic                     vga_enable,
  output logic                     scanlines_enable,
  output logic [2:0]               freq_option,
  output logic                     csync_option,
  output logic [1:0]               cpu_speed,
  output logic                     rasterint_enable,
  output logic                     vretraceint_disable,
  output logic [raster_line_w-1:0] raster_line,
  output logic [data_w-1:0]        devoptions
);

  zx_wdata_u         wr_view;
  zx_wdata_u         scandbl_q;
  zx_wdata_u         rasterctl_q;
  logic [data_w-1:0] rasterline_q;
  logic [data_w-1:0] devoptions_q;
  logic              rd_access;
  logic              reg_hit;

  // incoming byte seen through the union
  assign wr_view = zx.wdata;

  // --------------------
  // register writes
  // --------------------
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      scandbl_q    <= scandbl_rst;
      rasterline_q <= rasterline_rst;
      rasterctl_q  <= rasterctl_rst;
      devoptions_q <= devoptions_rst;
    end else if (zx.regwr) begin
      case (zx.reg_addr)
        reg_scandbl:    scandbl_q    <= wr_view;
        reg_rasterline: rasterline_q <= zx.wdata;
        reg_rasterctl:  rasterctl_q  <= wr_view;
        reg_devoptions: devoptions_q <= zx.wdata;
        // other numbers belong to someone else
        default: ;
      endcase
    end
  end

  // --------------------
  // decoded outputs
  // --------------------
  // scandoubler fields
  assign vga_enable       = scandbl_q.scandbl.vga_enable;
  assign scanlines_enable = scandbl_q.scandbl.scanlines_enable;
  assign freq_option      = scandbl_q.scandbl.freq_option;
  assign csync_option     = scandbl_q.scandbl.csync_option;
  assign cpu_speed        = scandbl_q.scandbl.cpu_speed;

  // raster interrupt fields
  assign rasterint_enable    = rasterctl_q.rasterctl.rasterint_enable;
  assign vretraceint_disable = rasterctl_q.rasterctl.vretraceint_disable;
  // msb lives in the control register
  assign raster_line = {rasterctl_q.rasterctl.line_msb, rasterline_q};

  assign devoptions = devoptions_q;

  // --------------------
  // read-back
  // --------------------
  assign rd_access = !iorq_n && !rd_n && (addr == port_zxdata);
  assign reg_hit   = zx.reg_addr inside {reg_scandbl, reg_rasterline,
                                         reg_rasterctl, reg_devoptions};
  // combinational, drops with the read
  assign oe = rd_access && reg_hit;

  always_comb begin
    case (zx.reg_addr)
      reg_scandbl:    dout = scandbl_q;
      reg_rasterline: dout = rasterline_q;
      reg_rasterctl:  dout = rasterctl_q;
      reg_devoptions: dout = devoptions_q;
      default:        dout = open_bus;
    endcase
  end

endmodule

// ==== rtl/coreid_reader.sv ====
module coreid_reader import zxuno_pkg::*; (
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic              rd_n,
  input  logic              iorq_n,
  input  logic [addr_w-1:0] addr,
  zxreg_if.sink             zx,
  output logic [data_w-1:0] dout,
  output logic              oe
);

  logic [coreid_ptr_w-1:0] ptr;
  logic [data_w-1:0]       char_q;
  logic                    hold;
  logic                    id_read;
  logic                    at_end;

  // regrd aimed at the id register
  assign id_read = zx.regrd && (zx.reg_addr == reg_coreid);
  // parked on the terminating zero
  assign at_end  = (ptr == coreid_ptr_w'(coreid_len - 1));

  // --------------------
  // pointer
  // --------------------
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      ptr  <= '0;
      hold <= 1'b0;
    end else begin
      if (zx.regaddr_changed)
        ptr <= '0;
      else if (id_read && !at_end)
        ptr <= ptr + 1'b1;
      // keep the old char until the bus cycle ends
      if (iorq_n)
        hold <= 1'b0;
      else if (id_read)
        hold <= 1'b1;
    end
  end

  // char read in this cycle
  always_ff @(posedge sysclk) begin
    if (id_read)
      char_q <= coreid_string[ptr];
  end

  assign oe   = !iorq_n && !rd_n && (addr == port_zxdata) && (zx.reg_addr == reg_coreid);
  assign dout = hold ? char_q : coreid_string[ptr];

endmodule

// ==== rtl/cpu_din_mux.sv ====
module cpu_din_mux import zxuno_pkg::*; (
  input  logic [data_w-1:0] addr_dout,
  input  logic              oe_addr,
  input  logic [data_w-1:0] bank_dout,
  input  logic              oe_bank,
  input  logic [data_w-1:0] coreid_dout,
  input  logic              oe_coreid,
  output logic [data_w-1:0] cpu_din
);

  // --------------------
  // fixed priority
  // --------------------
  // address read-back first
  // then core id, then the bank
  // open bus always last
  always_comb begin
    case (1'b1)
      oe_addr:   cpu_din = addr_dout;
      oe_coreid: cpu_din = coreid_dout;
      oe_bank:   cpu_din = bank_dout;
      default:   cpu_din = open_bus;
    endcase
  end

endmodule

// ==== rtl/zxuno_io_top.sv ====
module zxuno_io_top import zxuno_pkg::*; (
  input  logic                     sysclk,
  input  logic                     rst_n,
  input  logic [addr_w-1:0]        addr,
  input  logic                     iorq_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  input  logic [data_w-1:0]        din,
  output logic [data_w-1:0]        cpu_din,
  // scandoubler control
  output logic                     vga_enable,
  output logic                     scanlines_enable,
  output logic [2:0]               freq_option,
  output logic                     csync_option,
  output logic [1:0]               cpu_speed,
  // raster interrupt control
  output logic                     rasterint_enable,
  output logic                     vretraceint_disable,
  output logic [raster_line_w-1:0] raster_line,
  // device enables
  output logic [data_w-1:0]        devoptions
);

  // read sources toward the mux
  logic [data_w-1:0] addr_dout;
  logic              oe_addr;
  logic [data_w-1:0] bank_dout;
  logic              oe_bank;
  logic [data_w-1:0] coreid_dout;
  logic              oe_coreid;

  // decoded register accesses
  zxreg_if zx ();

  // --------------------
  // input side
  // --------------------
  zxreg_decoder u_decoder (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .addr      (addr),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .din       (din),
    .addr_dout (addr_dout),
    .oe_addr   (oe_addr),
    .zx        (zx.source)
  );

  // --------------------
  // register consumers
  // --------------------
  zxreg_bank u_bank (
    .sysclk              (sysclk),
    .rst_n               (rst_n),
    .rd_n                (rd_n),
    .iorq_n              (iorq_n),
    .addr                (addr),
    .zx                  (zx.sink),
    .dout                (bank_dout),
    .oe                  (oe_bank),
    .vga_enable          (vga_enable),
    .scanlines_enable    (scanlines_enable),
    .freq_option         (freq_option),
    .csync_option        (csync_option),
    .cpu_speed           (cpu_speed),
    .rasterint_enable    (rasterint_enable),
    .vretraceint_disable (vretraceint_disable),
    .raster_line         (raster_line),
    .devoptions          (devoptions)
  );

  coreid_reader u_coreid (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .rd_n   (rd_n),
    .iorq_n (iorq_n),
    .addr   (addr),
    .zx     (zx.sink),
    .dout   (coreid_dout),
    .oe     (oe_coreid)
  );

  // cpu data-in selection
  cpu_din_mux u_din_mux (
    .addr_dout   (addr_dout),
    .oe_addr     (oe_addr),
    .bank_dout   (bank_dout),
    .oe_bank     (oe_bank),
    .coreid_dout (coreid_dout),
    .oe_coreid   (oe_coreid),
    .cpu_din     (cpu_din)
  );

endmodule

// ==== testbench/zxuno_io_sva.sv ====
module zxuno_io_sva import zxuno_pkg::*; (
  input logic              sysclk,
  input logic              rst_n,
  input logic [addr_w-1:0] addr,
  input logic              iorq_n,
  input logic              wr_n,
  input logic              regwr,
  input logic              regrd,
  input logic              regaddr_changed
);

  logic any_strobe;

  assign any_strobe = regwr || regrd || regaddr_changed;

  // --------------------
  // strobe rules
  // --------------------
  // one access kind per bus cycle
  strobes_exclusive: assert property (
    @(posedge sysclk) disable iff (!rst_n)
      $onehot0({regwr, regrd, regaddr_changed})
  ) else $error("more than one register strobe high");

  // single cycle, bus cycles last at least 2 clocks
  strobe_one_cycle: assert property (
    @(posedge sysclk) disable iff (!rst_n)
      any_strobe |=> !any_strobe
  ) else $error("register strobe high for more than one cycle");

  // regwr needs a data port write on the edge before
  regwr_from_write: assert property (
    @(posedge sysclk) disable iff (!rst_n)
      regwr |-> $past(!iorq_n && !wr_n && (addr == port_zxdata))
  ) else $error("regwr without a write to the data port");

endmodule

bind zxreg_decoder zxuno_io_sva u_sva (
  .sysclk          (sysclk),
  .rst_n           (rst_n),
  .addr            (addr),
  .iorq_n          (iorq_n),
  .wr_n            (wr_n),
  .regwr           (regwr_q),
  .regrd           (regrd_q),
  .regaddr_changed (changed_q)
);

// ==== testbench/tb_zxuno_io.sv ====
module tb_zxuno_io import zxuno_pkg::*; ();

  // --------------------
  // run constants
  // --------------------
  localparam int          clk_period    = 100;
  localparam int          rst_cycles    = 16;
  localparam logic [31:0] lcg_seed      = 32'h86043f71;
  localparam string       data_file     = "testbench/zxuno_io_testdata.txt";
  localparam int          max_ops       = 256;
  // 3 active plus 2 idle cycles per bus operation
  localparam int          cycles_per_op = 5;
  localparam int          margin        = 100;

  logic                     sysclk;
  logic                     rst_n;
  logic [addr_w-1:0]        addr;
  logic                     iorq_n;
  logic                     rd_n;
  logic                     wr_n;
  logic [data_w-1:0]        din;
  logic [data_w-1:0]        cpu_din;
  logic                     vga_enable;
  logic                     scanlines_enable;
  logic [2:0]               freq_option;
  logic                     csync_option;
  logic [1:0]               cpu_speed;
  logic                     rasterint_enable;
  logic                     vretraceint_disable;
  logic [raster_line_w-1:0] raster_line;
  logic [data_w-1:0]        devoptions;

  // four words per line: op, port, value, expected
  logic [15:0]              td [0:4*max_ops-1];
  int                       n_ops;
  int                       cycle_count = 0;
  int                       cycle_limit = max_ops * cycles_per_op + rst_cycles + margin;
  logic [31:0]              rng;

  // register model
  logic [data_w-1:0]        m_latch;
  logic [data_w-1:0]        m_scandbl;
  logic [data_w-1:0]        m_rasterline;
  logic [data_w-1:0]        m_rasterctl;
  logic [data_w-1:0]        m_devoptions;
  logic [coreid_ptr_w-1:0]  m_id_ptr;

  zxuno_io_top UUT (
    .sysclk              (sysclk),
    .rst_n               (rst_n),
    .addr                (addr),
    .iorq_n              (iorq_n),
    .rd_n                (rd_n),
    .wr_n                (wr_n),
    .din                 (din),
    .cpu_din             (cpu_din),
    .vga_enable          (vga_enable),
    .scanlines_enable    (scanlines_enable),
    .freq_option         (freq_option),
    .csync_option        (csync_option),
    .cpu_speed           (cpu_speed),
    .rasterint_enable    (rasterint_enable),
    .vretraceint_disable (vretraceint_disable),
    .raster_line         (raster_line),
    .devoptions          (devoptions)
  );

  initial begin
    sysclk = 1'b0;
    forever #(clk_period / 2) sysclk = ~sysclk;
  end

  // --------------------
  // timeout
  // --------------------
  always @(posedge sysclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one z80 i/o cycle, entered and left on a falling edge
  task automatic bus_cycle(input logic [15:0] port, input logic is_write,
                           input logic [7:0] data, output logic [7:0] rdata);
    addr   = port;
    din    = is_write ? data : 8'h00;
    iorq_n = 1'b0;
    rd_n   = is_write;
    wr_n   = !is_write;
    repeat (3) @(negedge sysclk);
    // last falling edge of the cycle
    rdata  = cpu_din;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    wr_n   = 1'b1;
    repeat (2) @(negedge sysclk);
  endtask

  task automatic model_reset();
    m_latch      = 8'h00;
    m_scandbl    = 8'h00;
    // raster line all ones, its msb sits in bit 0 of the control byte
    m_rasterline = 8'hFF;
    m_rasterctl  = 8'h01;
    m_devoptions = 8'h00;
    m_id_ptr     = '0;
  endtask

  task automatic model_write(input logic [15:0] port, input logic [7:0] data);
    if (port == port_zxaddr) begin
      m_latch  = data;
      m_id_ptr = '0;
    end else if (port == port_zxdata) begin
      case (m_latch)
        reg_scandbl:    m_scandbl    = data;
        reg_rasterline: m_rasterline = data;
        reg_rasterctl:  m_rasterctl  = data;
        reg_devoptions: m_devoptions = data;
        default: ;
      endcase
    end
  endtask

  task automatic model_read(input logic [15:0] port, output logic [7:0] exp);
    exp = open_bus;
    if (port == port_zxaddr) begin
      exp = m_latch;
    end else if (port == port_zxdata) begin
      case (m_latch)
        reg_scandbl:    exp = m_scandbl;
        reg_rasterline: exp = m_rasterline;
        reg_rasterctl:  exp = m_rasterctl;
        reg_devoptions: exp = m_devoptions;
        reg_coreid: begin
          exp = coreid_string[m_id_ptr];
          // stays on the closing zero
          if (m_id_ptr < coreid_ptr_w'(coreid_len - 1))
            m_id_ptr = m_id_ptr + 1'b1;
        end
        default: exp = open_bus;
      endcase
    end
  endtask

  // field layout of the scandoubler and raster control bytes
  task automatic check_outputs();
    check_value("vga_enable", 16'(vga_enable), 16'(m_scandbl[0]));
    check_value("scanlines_enable", 16'(scanlines_enable), 16'(m_scandbl[1]));
    check_value("freq_option", 16'(freq_option), 16'(m_scandbl[4:2]));
    check_value("csync_option", 16'(csync_option), 16'(m_scandbl[5]));
    check_value("cpu_speed", 16'(cpu_speed), 16'(m_scandbl[7:6]));
    check_value("rasterint_enable", 16'(rasterint_enable), 16'(m_rasterctl[1]));
    check_value("vretraceint_disable", 16'(vretraceint_disable), 16'(m_rasterctl[2]));
    check_value("raster_line", 16'(raster_line), 16'({m_rasterctl[0], m_rasterline}));
    check_value("devoptions", 16'(devoptions), 16'(m_devoptions));
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    logic [15:0] op;
    logic [15:0] port;
    logic [15:0] value;
    logic [15:0] exp_val;
    logic [9:0]  base;
    logic [7:0]  rdata;
    logic [7:0]  wdata;
    logic [7:0]  predicted;

    rst_n  = 1'b0;
    addr   = '0;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    wr_n   = 1'b1;
    din    = '0;
    rng    = lcg_seed;
    for (int i = 0; i < 4 * max_ops; i++)
      td[i] = 16'h0000;
    $readmemh(data_file, td);

    // find the end marker, op F
    n_ops = -1;
    for (int i = 0; i < max_ops; i++) begin
      base = 10'(4 * i);
      if (n_ops < 0 && td[base] == 16'h000F)
        n_ops = i;
    end
    if (n_ops < 0) begin
      $display("test data could not be read or has no end marker");
      $display("TEST FAIL");
      $fatal(1, "bad test data");
    end
    cycle_limit = n_ops * cycles_per_op + rst_cycles + margin;

    model_reset();
    repeat (rst_cycles) @(negedge sysclk);
    rst_n = 1'b1;

    for (int i = 0; i < n_ops; i++) begin
      base    = 10'(4 * i);
      op      = td[base];
      port    = td[base + 10'd1];
      value   = td[base + 10'd2];
      exp_val = td[base + 10'd3];
      case (op)
        16'h0001: begin
          bus_cycle(port, 1'b1, value[7:0], rdata);
          model_write(port, value[7:0]);
        end
        16'h0002: begin
          bus_cycle(port, 1'b0, 8'h00, rdata);
          model_read(port, predicted);
          check_value("read data", 16'(rdata), exp_val);
          check_value("model read", 16'(rdata), 16'(predicted));
        end
        16'h0003: begin
          rng   = lcg_next(rng);
          wdata = rng[23:16];
          bus_cycle(port, 1'b1, wdata, rdata);
          model_write(port, wdata);
        end
        16'h0004: begin
          bus_cycle(port, 1'b0, 8'h00, rdata);
          model_read(port, predicted);
          check_value("model read", 16'(rdata), 16'(predicted));
        end
        16'h0005: begin
          check_outputs();
          @(negedge sysclk);
        end
        16'h0006: begin
          check_value("raster_line", 16'(raster_line), exp_val);
          @(negedge sysclk);
        end
        default: begin
          $display("unknown operation %0h on test data line %0d", op, i);
          $display("TEST FAIL");
          $fatal(1, "bad test data");
        end
      endcase
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== testbench/zxuno_io_testdata.txt ====
// columns: op port value expected, hex; op 1 write, 2 read, 3 random write,
// 4 read against model, 5 check outputs, 6 check raster_line, F end
5 0000 00 000
6 0000 00 1FF
2 FC3B 00 000
1 FC3B 55 000
2 FC3B 00 055
2 FD3B 00 0FF
1 FC3B A7 000
2 FC3B 00 0A7
1 FC3B 0C 000
1 FD3B 34 000
2 FD3B 00 034
1 FC3B 0D 000
1 FD3B 07 000
2 FD3B 00 007
6 0000 00 134
5 0000 00 000
1 FC3B 0B 000
3 FD3B 00 000
4 FD3B 00 000
5 0000 00 000
1 FC3B 0C 000
3 FD3B 00 000
4 FD3B 00 000
1 FC3B 0D 000
3 FD3B 00 000
4 FD3B 00 000
1 FC3B 0E 000
3 FD3B 00 000
4 FD3B 00 000
5 0000 00 000
1 FC3B FF 000
2 FD3B 00 05A
2 FD3B 00 058
2 FD3B 00 049
2 FD3B 00 04F
2 FD3B 00 02D
2 FD3B 00 052
2 FD3B 00 031
2 FD3B 00 000
2 FD3B 00 000
1 FC3B FF 000
2 FD3B 00 05A
4 FD3B 00 000
2 00FE 00 0FF
1 00FE 3C 000
2 7FFD 00 0FF
5 0000 00 000
2 FC3B 00 0FF
F 0000 00 000

// ==== list.f ====
rtl/zxuno_pkg.sv
rtl/zxreg_if.sv
rtl/zxreg_decoder.sv
rtl/zxreg_bank.sv
rtl/coreid_reader.sv
rtl/cpu_din_mux.sv
rtl/zxuno_io_top.sv
testbench/zxuno_io_sva.sv
testbench/tb_zxuno_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_zxuno_io
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
